// File: src/sha256_pkg.sv
/* SHA-256 shared types, round constants and round functions
   for the second-chunk pipeline of an 80-byte block header */
package sha256_pkg;

	typedef logic [31:0]  word_t;
	// Word a in the top 32 bits, word h in the bottom
	typedef logic [255:0] state_t;
	// Message word 0 in the top 32 bits
	typedef logic [127:0] tail_t;
	// Word used by the current round sits in bits 31:0
	typedef logic [511:0] window_t;

	localparam int NUM_ROUNDS = 64;

	localparam word_t ROUND_K [0:NUM_ROUNDS-1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Padding for a 640-bit message: leading one bit, then the length
	localparam word_t PAD_WORD = 32'h80000000;
	localparam word_t LEN_WORD = 32'h00000280;

	localparam state_t sha256_iv = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// Bitwise select: f where e is set, g elsewhere
	function automatic word_t ch(input word_t e, input word_t f, input word_t g);
		return (e & f) ^ (~e & g);
	endfunction

	// Bitwise majority of three words
	function automatic word_t maj(input word_t a, input word_t b, input word_t c);
		return (a & b) ^ (a & c) ^ (b & c);
	endfunction

endpackage

// File: src/sha256_sched_stage.sv
/* SHA-256 message schedule step
   shifts the 16-word window down and appends the next expanded word */
module sha256_sched_stage (
	input  logic                CLK,
	input  logic                RST,
	input  logic                advance_i,
	input  sha256_pkg::window_t window_i,
	output sha256_pkg::window_t window_o
);
	import sha256_pkg::*;

	word_t   w0;
	word_t   w1;
	word_t   w9;
	word_t   w14;
	word_t   w_new;
	window_t window_next;

	assign w0  = window_i[32*0 +: 32];
	assign w1  = window_i[32*1 +: 32];
	assign w9  = window_i[32*9 +: 32];
	assign w14 = window_i[32*14 +: 32];

	// W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
	assign w_new = small_sigma1(w14) + w9 + small_sigma0(w1) + w0;

	// Word 0 has been consumed by its round and drops out
	assign window_next = {w_new, window_i[511:32]};

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			window_o <= '0;
		end else if (advance_i) begin
			window_o <= window_next;
		end
	end

	a_hold_on_stall: assert property (
		@(posedge CLK) disable iff (!RST)
		!advance_i |=> $stable(window_o)
	) else $error("schedule window changed while the pipeline was stalled");

endmodule

// File: src/sha256_round_stage.sv
/* SHA-256 compression round, one pipeline stage
   carries the item's valid bit and midstate alongside the working variables */
module sha256_round_stage #(
	parameter int ROUND = 0
) (
	input  logic               CLK,
	input  logic               RST,
	input  logic               advance_i,
	input  logic               valid_i,
	input  sha256_pkg::state_t state_i,
	input  sha256_pkg::state_t midstate_i,
	input  sha256_pkg::word_t  w_i,
	output logic               valid_o,
	output sha256_pkg::state_t state_o,
	output sha256_pkg::state_t midstate_o
);
	import sha256_pkg::*;

	word_t  a;
	word_t  b;
	word_t  c;
	word_t  d;
	word_t  e;
	word_t  f;
	word_t  g;
	word_t  h;
	word_t  k;
	word_t  t1;
	word_t  t2;
	state_t state_next;

	if (ROUND < 0 || ROUND >= NUM_ROUNDS) begin : g_bad_round
		$error("ROUND out of range");
	end

	assign {a, b, c, d, e, f, g, h} = state_i;
	assign k = ROUND_K[ROUND];

	assign t1 = h + big_sigma1(e) + ch(e, f, g) + k + w_i;
	assign t2 = big_sigma0(a) + maj(a, b, c);

	// New a and e; the rest shift down by one position
	assign state_next = {t1 + t2, a, b, c, d + t1, e, f, g};

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			valid_o    <= 1'b0;
			state_o    <= '0;
			midstate_o <= '0;
		end else if (advance_i) begin
			valid_o    <= valid_i;
			state_o    <= state_next;
			midstate_o <= midstate_i;
		end
	end

	a_valid_known: assert property (
		@(posedge CLK) disable iff (!RST)
		!$isunknown(valid_o)
	) else $error("round %0d valid bit is unknown", ROUND);

endmodule

// File: src/sha256_digest_final.sv
/* SHA-256 feed-forward and output register
   adds the midstate to the last working variables to form the digest */
module sha256_digest_final (
	input  logic               CLK,
	input  logic               RST,
	input  logic               advance_i,
	input  logic               valid_i,
	input  sha256_pkg::state_t state_i,
	input  sha256_pkg::state_t midstate_i,
	output sha256_pkg::state_t digest_o,
	output logic               valid_o
);
	import sha256_pkg::*;

	localparam int NUM_WORDS = $bits(state_t) / $bits(word_t);

	state_t digest_next;

	// Word-wise add modulo 2^32, bubbles give an all-zero digest
	always_comb begin
		digest_next = '0;
		if (valid_i) begin
			for (int i = 0; i < NUM_WORDS; i++) begin
				digest_next[32*i +: 32] = state_i[32*i +: 32] + midstate_i[32*i +: 32];
			end
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			digest_o <= '0;
			valid_o  <= 1'b0;
		end else if (advance_i) begin
			digest_o <= digest_next;
			valid_o  <= valid_i;
		end
	end

	a_zero_when_idle: assert property (
		@(posedge CLK) disable iff (!RST)
		!valid_o |-> (digest_o == '0)
	) else $error("digest is nonzero without valid");

endmodule

// File: src/sha256_tail_core.sv
/* Fully pipelined SHA-256 over the padded second chunk of an 80-byte header
   one round per stage, one item per advancing cycle, 65-cycle latency */
module sha256_tail_core (
	input  logic               CLK,
	input  logic               RST,
	input  logic               advance_i,
	input  logic               load_i,
	input  sha256_pkg::state_t midstate_i,
	input  sha256_pkg::tail_t  tail_i,
	output sha256_pkg::state_t digest_o,
	output logic               valid_o
);
	import sha256_pkg::*;

	window_t window_0;

	// Entry t feeds round stage t, entry NUM_ROUNDS feeds the final adder
	state_t  state_chain [0:NUM_ROUNDS];
	state_t  mid_chain   [0:NUM_ROUNDS];
	logic    valid_chain [0:NUM_ROUNDS];
	// Entry t holds the schedule window seen by round t
	window_t win_chain   [0:NUM_ROUNDS-1];

	// Tail words 0..3 go to the bottom of the window, word 0 first
	always_comb begin
		window_0 = '0;
		for (int i = 0; i < 4; i++) begin
			window_0[32*i +: 32] = tail_i[32*(3-i) +: 32];
		end
		window_0[32*4 +: 32]  = PAD_WORD;
		window_0[32*15 +: 32] = LEN_WORD;
	end

	assign state_chain[0] = midstate_i;
	assign mid_chain[0]   = midstate_i;
	assign valid_chain[0] = load_i;
	assign win_chain[0]   = window_0;

	genvar t;

	for (t = 0; t < NUM_ROUNDS; t++) begin : g_round
		sha256_round_stage #(
			.ROUND(t)
		) u_round (
			.CLK        (CLK),
			.RST        (RST),
			.advance_i  (advance_i),
			.valid_i    (valid_chain[t]),
			.state_i    (state_chain[t]),
			.midstate_i (mid_chain[t]),
			.w_i        (win_chain[t][31:0]),
			.valid_o    (valid_chain[t+1]),
			.state_o    (state_chain[t+1]),
			.midstate_o (mid_chain[t+1])
		);
	end

	// Round 63 uses the last window, so one fewer schedule step
	for (t = 0; t < NUM_ROUNDS - 1; t++) begin : g_sched
		sha256_sched_stage u_sched (
			.CLK       (CLK),
			.RST       (RST),
			.advance_i (advance_i),
			.window_i  (win_chain[t]),
			.window_o  (win_chain[t+1])
		);
	end

	sha256_digest_final u_final (
		.CLK        (CLK),
		.RST        (RST),
		.advance_i  (advance_i),
		.valid_i    (valid_chain[NUM_ROUNDS]),
		.state_i    (state_chain[NUM_ROUNDS]),
		.midstate_i (mid_chain[NUM_ROUNDS]),
		.digest_o   (digest_o),
		.valid_o    (valid_o)
	);

endmodule

// File: tests/sha256_ref_model.svh
/* SHA-256 software model of the padded second chunk
   plus the xorshift generator for random stimulus */
`ifndef SHA256_REF_MODEL_SVH
`define SHA256_REF_MODEL_SVH

localparam word_t SHA_K [0:63] = '{
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
	32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
	32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
	32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
	32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
	32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
	32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
	32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
	32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
	32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
	32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

word_t rng_state = 32'ha7c7;

function automatic word_t rotate_right(input word_t x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

function automatic word_t cap_sigma0(input word_t x);
	return rotate_right(x, 2) ^ rotate_right(x, 13) ^ rotate_right(x, 22);
endfunction

function automatic word_t cap_sigma1(input word_t x);
	return rotate_right(x, 6) ^ rotate_right(x, 11) ^ rotate_right(x, 25);
endfunction

function automatic word_t low_sigma0(input word_t x);
	return rotate_right(x, 7) ^ rotate_right(x, 18) ^ (x >> 3);
endfunction

function automatic word_t low_sigma1(input word_t x);
	return rotate_right(x, 17) ^ rotate_right(x, 19) ^ (x >> 10);
endfunction

// Full compression of the padded chunk, midstate added at the end
function automatic state_t compress_chunk(input state_t mid, input tail_t tail);
	word_t  w [0:63];
	word_t  v [0:7];
	word_t  t1;
	word_t  t2;
	state_t result;
	for (int i = 0; i < 16; i++) begin
		w[i] = '0;
	end
	for (int i = 0; i < 4; i++) begin
		w[i] = tail[127 - 32*i -: 32];
	end
	w[4]  = 32'h80000000;
	w[15] = 32'd640;
	for (int i = 16; i < 64; i++) begin
		w[i] = low_sigma1(w[i-2]) + w[i-7] + low_sigma0(w[i-15]) + w[i-16];
	end
	for (int i = 0; i < 8; i++) begin
		v[i] = mid[255 - 32*i -: 32];
	end
	for (int i = 0; i < 64; i++) begin
		t1 = v[7] + cap_sigma1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA_K[i] + w[i];
		t2 = cap_sigma0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int j = 7; j > 0; j--) begin
			v[j] = v[j-1];
		end
		v[4] = v[4] + t1;
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++) begin
		result[255 - 32*i -: 32] = v[i] + mid[255 - 32*i -: 32];
	end
	return result;
endfunction

function automatic word_t next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

function automatic state_t random_state();
	state_t s;
	s = '0;
	for (int i = 0; i < 8; i++) begin
		s = {s[223:0], next_rand()};
	end
	return s;
endfunction

function automatic tail_t random_tail();
	tail_t s;
	s = '0;
	for (int i = 0; i < 4; i++) begin
		s = {s[95:0], next_rand()};
	end
	return s;
endfunction

`endif

// File: tests/tb_sha256_tail_core.sv
/* Testbench for the pipelined SHA-256 tail core
   directed tests, outputs checked every cycle against a software model */
module tb_sha256_tail_core;
	import sha256_pkg::*;

	`include "sha256_ref_model.svh"

	// Tests take about 510 cycles, three times that before giving up
	localparam int MAX_CYCLES  = 1500;
	localparam int LATENCY     = 65;
	localparam int DRAIN_LIMIT = 100;
	// Set bits mark bubble cycles
	localparam logic [23:0] BUBBLE_MASK = 24'b1100_0010_0011_0000_1000_0101;

	logic   CLK;
	logic   RST;
	logic   advance_i;
	logic   load_i;
	state_t midstate_i;
	tail_t  tail_i;
	state_t digest_o;
	logic   valid_o;

	// One entry per advancing cycle still inside the pipeline
	logic   exp_valid_q [$];
	state_t exp_digest_q [$];
	logic   want_valid = 1'b0;
	state_t want_digest = '0;
	int     accepted = 0;
	int     delivered = 0;
	int     cycle_count = 0;

	sha256_tail_core DUT (
		.CLK        (CLK),
		.RST        (RST),
		.advance_i  (advance_i),
		.load_i     (load_i),
		.midstate_i (midstate_i),
		.tail_i     (tail_i),
		.digest_o   (digest_o),
		.valid_o    (valid_o)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_digest(input string name, input state_t got, input state_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL at time %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL at time %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic drive_cycle(input logic adv, input logic ld, input state_t mid, input tail_t tl);
		@(posedge CLK);
		#1;
		advance_i  = adv;
		load_i     = ld;
		midstate_i = mid;
		tail_i     = tl;
	endtask

	task automatic drive_item(input state_t mid, input tail_t tl);
		drive_cycle(1'b1, 1'b1, mid, tl);
	endtask

	task automatic drive_idle();
		drive_cycle(1'b1, 1'b0, '0, '0);
	endtask

	// Load held high with junk data, none of it may enter
	task automatic drive_stall();
		drive_cycle(1'b0, 1'b1, random_state(), random_tail());
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		drive_idle();
		@(negedge CLK);
		while (delivered != accepted) begin
			if (n >= DRAIN_LIMIT) begin
				abort_run("items never drained out of the pipeline");
			end
			drive_idle();
			@(negedge CLK);
			n++;
		end
	endtask

	task automatic test_idle_after_reset();
		for (int i = 0; i < 70; i++) begin
			drive_idle();
			@(negedge CLK);
			check_valid("valid_o", valid_o, 1'b0);
			check_digest("digest_o", digest_o, '0);
		end
	endtask

	task automatic test_single_item();
		tail_t  tail;
		state_t expected;
		int     edges;
		tail     = {32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d, 32'h1dac2b7c};
		expected = compress_chunk(sha256_iv, tail);
		drive_item(sha256_iv, tail);
		edges = 0;
		do begin
			drive_idle();
			edges++;
		end while (valid_o !== 1'b1 && edges < LATENCY + 10);
		if (edges != LATENCY) begin
			abort_run($sformatf("single item took %0d advancing cycles instead of %0d",
				edges, LATENCY));
		end
		check_digest("digest_o", digest_o, expected);
		wait_drain();
	endtask

	task automatic test_back_to_back();
		int start;
		start = delivered;
		for (int i = 0; i < 20; i++) begin
			drive_item(random_state(), random_tail());
		end
		wait_drain();
		if (delivered - start != 20) begin
			abort_run($sformatf("back-to-back stream delivered %0d items instead of 20",
				delivered - start));
		end
	endtask

	task automatic test_random_stalls();
		int start;
		int len;
		start = delivered;
		for (int i = 0; i < 20; i++) begin
			if (i == 0 || next_rand() % 3 == 0) begin
				len = 1 + next_rand() % 5;
				repeat (len) drive_stall();
			end
			drive_item(random_state(), random_tail());
		end
		// Stall again while the digests come out, so valid outputs must hold
		for (int i = 0; i < LATENCY + 5; i++) begin
			if (i % 4 == 0) begin
				len = 1 + next_rand() % 5;
				repeat (len) drive_stall();
			end
			drive_idle();
		end
		wait_drain();
		if (delivered - start != 20) begin
			abort_run($sformatf("stalled stream delivered %0d items instead of 20",
				delivered - start));
		end
	endtask

	task automatic test_bubbles();
		int start;
		int items;
		start = delivered;
		items = 0;
		for (int i = 0; i < 24; i++) begin
			if (BUBBLE_MASK[i]) begin
				drive_idle();
			end else begin
				drive_item(random_state(), random_tail());
				items++;
			end
		end
		wait_drain();
		if (delivered - start != items) begin
			abort_run($sformatf("bubble stream delivered %0d items instead of %0d",
				delivered - start, items));
		end
	endtask

	// Scoreboard, every advancing cycle retires the entry pushed 64 advancing cycles before
	initial begin
		logic   adv;
		logic   ld;
		state_t zero;
		zero = '0;
		for (int i = 0; i < LATENCY - 1; i++) begin
			exp_valid_q.push_back(1'b0);
			exp_digest_q.push_back(zero);
		end
		forever begin
			@(posedge CLK);
			adv = advance_i && RST;
			ld  = load_i;
			if (adv) begin
				exp_valid_q.push_back(ld);
				if (ld) begin
					exp_digest_q.push_back(compress_chunk(midstate_i, tail_i));
					accepted++;
				end else begin
					exp_digest_q.push_back(zero);
				end
				want_valid  = exp_valid_q.pop_front();
				want_digest = exp_digest_q.pop_front();
			end
			@(negedge CLK);
			check_valid("valid_o", valid_o, want_valid);
			check_digest("digest_o", digest_o, want_digest);
			if (adv && want_valid) begin
				delivered++;
			end
		end
	end

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge CLK);
			cycle_count++;
		end
		abort_run("timeout: digest never arrived");
	end

	initial begin
		RST        = 1'b0;
		advance_i  = 1'b0;
		load_i     = 1'b0;
		midstate_i = '0;
		tail_i     = '0;
		repeat (10) @(posedge CLK);
		#1;
		RST = 1'b1;
		test_idle_after_reset();
		test_single_item();
		test_back_to_back();
		test_random_stalls();
		test_bubbles();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: build.f
+incdir+tests
src/sha256_pkg.sv
src/sha256_sched_stage.sv
src/sha256_round_stage.sv
src/sha256_digest_final.sv
src/sha256_tail_core.sv
tests/tb_sha256_tail_core.sv
